// ==== cache_patterns.txt ====
// columns: op address wstrb wdata expected_rdata, all hex
// op 0 read, 1 write, 10 or 11 when it must hit; expected is unused for writes; ff ends
00 00001000 0 00000000 ffffefff
10 00001008 0 00000000 ffffeff7
10 00001000 0 00000000 ffffefff
11 00001004 3 12345678 00000000
10 00001004 0 00000000 ffff5678
11 0000100c 8 ab000000 00000000
10 0000100c 0 00000000 abffeff3
01 00002014 5 11223344 00000000
10 00002014 0 00000000 ff22df44
10 00002018 0 00000000 ffffdfe7
01 00003050 f aaaa0003 00000000
01 00004050 f aaaa0004 00000000
01 00005050 f aaaa0005 00000000
00 00003050 0 00000000 aaaa0003
00 00004050 0 00000000 aaaa0004
00 00005050 0 00000000 aaaa0005
00 00003054 0 00000000 ffffcfab
ff 00000000 0 00000000 00000000

// ==== sim.f ====
cache_pkg.sv
cache_ctrl.sv
cache_tag_array.sv
cache_data_array.sv
cache_miss_unit.sv
cache_top.sv
tb_mem_model.sv
tb_cache.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cache -f sim.f -o sim_cache
	./obj_dir/sim_cache | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;

    localparam int max_pat    = 64;
    localparam int wait_limit = 400;

    logic                clk;
    logic                reset;
    logic                valid;
    cache_pkg::cpu_req_t req;
    logic                addr_ok;
    logic                data_ok;
    logic [31:0]         rdata;
    logic                rd_req;
    cache_pkg::rd_bus_t  rd_bus;
    logic                rd_rdy;
    logic                ret_valid;
    logic                ret_last;
    logic [31:0]         ret_data;
    logic                wr_req;
    cache_pkg::wr_bus_t  wr_bus;
    logic                wr_rdy;

    logic [31:0] pat [max_pat*5]; // five columns per access
    logic [31:0] cur_addr;
    int          errors;
    int          timeouts;
    int          rd_count;
    int          wb_count;

    cache_top u_cache_top (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .req       (req),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_rdy    (wr_rdy),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_bus    (rd_bus),
        .wr_req    (wr_req),
        .wr_bus    (wr_bus)
    );

    tb_mem_model u_mem (
        .clk       (clk),
        .reset     (reset),
        .rd_req    (rd_req),
        .rd_bus    (rd_bus),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_bus    (wr_bus),
        .wr_rdy    (wr_rdy)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // bus monitor samples the handshakes at the falling edge
    always @(negedge clk) begin
        if (!reset && rd_req && rd_rdy) begin
            rd_count++;
            check_value("rd_bus.rd_type", {29'b0, rd_bus.rd_type}, 32'h4);
            check_value("rd_bus.rd_addr", rd_bus.rd_addr,
                        {cur_addr[31:4], 4'h0}); // line of the current access
        end
        if (!reset && wr_req && wr_rdy) begin
            wb_count++;
            check_value("wr_bus.wr_type", {29'b0, wr_bus.wr_type}, 32'h4);
            check_value("wr_bus.wr_addr index", {24'b0, wr_bus.wr_addr[11:4]},
                        {24'b0, cur_addr[11:4]});
        end
    end

    // bit 0 of the op column is the op and bit 4 marks an access that must hit
    task automatic run_access(input logic [31:0] op_col, input logic [31:0] addr,
                              input logic [31:0] strb, input logic [31:0] wdata,
                              input logic [31:0] exp);
        int waited;
        int reads_before;
        waited       = 0;
        reads_before = rd_count;
        @(negedge clk);
        while (!addr_ok && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!addr_ok) begin
            $display("timeout: the cache never accepted the access to %h", addr);
            timeouts++;
        end else begin
            @(posedge clk);
            #1;
            cur_addr     = addr;
            valid        = 1'b1;
            req.op       = op_col[0];
            req.addr.raw = addr;
            req.wstrb    = strb[3:0];
            req.wdata    = wdata;
            @(posedge clk); // accept edge
            #1;
            valid  = 1'b0;
            waited = 0;
            @(negedge clk);
            while (!data_ok && waited < wait_limit) begin
                @(negedge clk);
                waited++;
            end
            if (!data_ok) begin
                $display("timeout: no data_ok for the access to %h", addr);
                timeouts++;
            end else begin
                if (op_col[0] == cache_pkg::op_read) begin
                    check_value("rdata", rdata, exp);
                end
                if (op_col[4]) begin
                    check_value("hit latency", waited, 0); // data_ok right after accept
                    check_value("rd_req count", rd_count - reads_before, 0);
                end
            end
        end
    endtask

    initial begin
        int i;
        clk      = 1'b0;
        reset    = 1'b1;
        valid    = 1'b0;
        req      = '0;
        cur_addr = '0;
        errors   = 0;
        timeouts = 0;
        rd_count = 0;
        wb_count = 0;
        for (int k = 0; k < max_pat*5; k++) begin
            pat[k] = 32'hff; // end marker where the file stops
        end
        $readmemh("cache_patterns.txt", pat);

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("addr_ok", {31'b0, addr_ok}, 32'd1);
        check_value("data_ok", {31'b0, data_ok}, 32'd0);
        check_value("rd_req", {31'b0, rd_req}, 32'd0);
        check_value("wr_req", {31'b0, wr_req}, 32'd0);

        i = 0;
        while (i < max_pat && pat[i*5] != 32'hff && timeouts == 0) begin
            run_access(pat[i*5], pat[i*5+1], pat[i*5+2], pat[i*5+3], pat[i*5+4]);
            i++;
        end
        if (timeouts == 0) begin
            check_value("write-back seen", {31'b0, wb_count != 0}, 32'd1);
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model (
    input  logic               clk,
    input  logic               reset,
    input  logic               rd_req,
    input  cache_pkg::rd_bus_t rd_bus,
    output logic               rd_rdy,
    output logic               ret_valid,
    output logic               ret_last,
    output logic [31:0]        ret_data,
    input  logic               wr_req,
    input  cache_pkg::wr_bus_t wr_bus,
    output logic               wr_rdy
);

    logic [31:0] mem [logic [31:0]]; // sparse, only written words are stored
    integer      seed;

    // untouched words read back as their own byte address inverted
    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return ~a;
    endfunction

    initial begin
        seed      = 70535;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
    end

    // one bus transfer at a time, outputs change 1 ns after the edge
    always begin : serve_bus
        logic [31:0]      base;
        cache_pkg::line_t line;
        int               gap;
        @(posedge clk);
        #1;
        if (!reset && wr_req) begin
            gap = $unsigned($random(seed)) % 4; // random acceptance delay
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            base   = wr_bus.wr_addr;
            line   = wr_bus.wr_data;
            wr_rdy = 1'b1;
            @(posedge clk);
            #1;
            wr_rdy = 1'b0;
            for (int i = 0; i < 4; i++) begin
                mem[base + 32'(4 * i)] = line[i*32 +: 32];
            end
        end else if (!reset && rd_req) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            base   = rd_bus.rd_addr;
            rd_rdy = 1'b1;
            @(posedge clk);
            #1;
            rd_rdy = 1'b0;
            for (int i = 0; i < 4; i++) begin
                ret_valid = 1'b1;
                ret_last  = (i == 3);
                ret_data  = read_word(base + 32'(4 * i)); // lowest word first
                @(posedge clk);
                #1;
            end
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
    end

endmodule

// ==== cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  cache_pkg::cpu_req_t req,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  logic [31:0]         ret_data,
    input  logic                wr_rdy,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [31:0]         rdata,
    output logic                rd_req,
    output cache_pkg::rd_bus_t  rd_bus,
    output logic                wr_req,
    output cache_pkg::wr_bus_t  wr_bus
);

    cache_pkg::state_t           state;
    cache_pkg::cpu_req_t         req_q;
    logic                        hit;
    logic                        hit_way;
    logic                        victim_dirty;
    logic [cache_pkg::tag_w-1:0] victim_tag;
    logic                        tag_we;
    logic                        commit_hit_write;
    logic                        victim_way;
    logic [1:0]                  beat_index;
    logic [31:0]                 refill_word;
    logic                        refill_we;
    logic [31:0]                 miss_rdata;
    logic [31:0]                 hit_word;
    cache_pkg::line_t            victim_line;

    cache_ctrl u_cache_ctrl (
        .clk              (clk),
        .reset            (reset),
        .valid            (valid),
        .req              (req),
        .hit              (hit),
        .victim_dirty     (victim_dirty),
        .rd_rdy           (rd_rdy),
        .ret_valid        (ret_valid),
        .ret_last         (ret_last),
        .wr_rdy           (wr_rdy),
        .state            (state),
        .req_q            (req_q),
        .addr_ok          (addr_ok),
        .data_ok          (data_ok),
        .rd_req           (rd_req),
        .wr_req           (wr_req),
        .tag_we           (tag_we),
        .commit_hit_write (commit_hit_write)
    );

    cache_tag_array u_cache_tag_array (
        .clk               (clk),
        .reset             (reset),
        .lookup_addr       (req_q.addr),
        .victim_way        (victim_way),
        .tag_we            (tag_we),
        .commit_hit_write  (commit_hit_write),
        .hit_way_set_dirty (req_q.op == cache_pkg::op_write),
        .hit               (hit),
        .hit_way           (hit_way),
        .victim_dirty      (victim_dirty),
        .victim_tag        (victim_tag)
    );

    cache_data_array u_cache_data_array (
        .clk              (clk),
        .req_q            (req_q),
        .state            (state),
        .hit_way          (hit_way),
        .commit_hit_write (commit_hit_write),
        .victim_way       (victim_way),
        .beat_index       (beat_index),
        .refill_word      (refill_word),
        .refill_we        (refill_we),
        .hit_word         (hit_word),
        .victim_line      (victim_line)
    );

    cache_miss_unit u_cache_miss_unit (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .req_q       (req_q),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .victim_way  (victim_way),
        .beat_index  (beat_index),
        .refill_word (refill_word),
        .refill_we   (refill_we),
        .miss_rdata  (miss_rdata)
    );

    // block addresses, line aligned
    assign rd_bus.rd_type = cache_pkg::bus_block;
    assign rd_bus.rd_addr = {req_q.addr.f.tag, req_q.addr.f.index,
                             {cache_pkg::offset_w{1'b0}}};

    assign wr_bus.wr_type = cache_pkg::bus_block;
    assign wr_bus.wr_addr = {victim_tag, req_q.addr.f.index, {cache_pkg::offset_w{1'b0}}};
    assign wr_bus.wr_data = victim_line;

    assign rdata = (state == cache_pkg::lookup) ? hit_word : miss_rdata;

endmodule

// ==== cache_miss_unit.sv ====
`timescale 1ns/1ps

module cache_miss_unit (
    input  logic                clk,
    input  logic                reset,
    input  cache_pkg::state_t   state,
    input  cache_pkg::cpu_req_t req_q,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  logic [31:0]         ret_data,
    output logic                victim_way,
    output logic [1:0]          beat_index,
    output logic [31:0]         refill_word,
    output logic                refill_we,
    output logic [31:0]         miss_rdata
);

    logic [2:0]  lfsr;
    logic        in_refill;
    logic        req_beat;
    logic [31:0] merged_word;
    logic [31:0] rdata_q;

    assign in_refill  = (state == cache_pkg::refill);
    assign refill_we  = in_refill && ret_valid;
    assign req_beat   = refill_we && (beat_index == req_q.addr.f.bank);
    assign victim_way = lfsr[0];

    // replacement choice, moves on only when a refill completes
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= 3'b111;
        end else if (refill_we && ret_last) begin
            lfsr <= {lfsr[0], lfsr[2] ^ lfsr[0], lfsr[1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_index <= '0;
        end else if (!in_refill) begin
            beat_index <= '0;
        end else if (ret_valid) begin
            beat_index <= beat_index + 2'd1;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged_word[i*8 +: 8] = req_q.wstrb[i] ? req_q.wdata[i*8 +: 8]
                                                   : ret_data[i*8 +: 8];
        end
    end

    // store bytes land in the refilled line directly
    assign refill_word = (req_beat && req_q.op == cache_pkg::op_write) ? merged_word
                                                                        : ret_data;

    always_ff @(posedge clk) begin
        if (req_beat && req_q.op == cache_pkg::op_read) begin
            rdata_q <= ret_data;
        end
    end

    // the requested word may arrive on the last beat itself
    assign miss_rdata = req_beat ? ret_data : rdata_q;

    // memory ends every block after exactly words_per_line beats
    a_last_beat: assert property (@(posedge clk) disable iff (reset)
        (refill_we && ret_last) |-> (beat_index == cache_pkg::words_per_line - 1));

endmodule

// ==== cache_data_array.sv ====
`timescale 1ns/1ps

module cache_data_array (
    input  logic                clk,
    input  cache_pkg::cpu_req_t req_q,
    input  cache_pkg::state_t   state,
    input  logic                hit_way,
    input  logic                commit_hit_write,
    input  logic                victim_way,
    input  logic [1:0]          beat_index,
    input  logic [31:0]         refill_word,
    input  logic                refill_we,
    output logic [31:0]         hit_word,
    output cache_pkg::line_t    victim_line
);

    localparam int nbanks = cache_pkg::words_per_line;

    logic [31:0]                   bank_mem [2][nbanks][cache_pkg::num_sets];
    logic [cache_pkg::index_w-1:0] idx;
    logic                          rd_way;
    cache_pkg::line_t              rd_line;

    assign idx = req_q.addr.f.index;

    // one line read port: hit way while looking up, victim way otherwise
    assign rd_way = (state == cache_pkg::lookup) ? hit_way : victim_way;

    always_comb begin
        for (int b = 0; b < nbanks; b++) begin
            rd_line[b*32 +: 32] = bank_mem[rd_way][b][idx];
        end
    end

    assign hit_word    = rd_line[req_q.addr.f.bank*32 +: 32];
    assign victim_line = rd_line; // write-back payload

    always_ff @(posedge clk) begin
        if (commit_hit_write) begin
            for (int i = 0; i < 4; i++) begin
                if (req_q.wstrb[i]) begin
                    bank_mem[hit_way][req_q.addr.f.bank][idx][i*8 +: 8] <=
                        req_q.wdata[i*8 +: 8];
                end
            end
        end else if (refill_we) begin
            bank_mem[victim_way][beat_index][idx] <= refill_word; // full bank per beat
        end
    end

endmodule

// ==== cache_tag_array.sv ====
`timescale 1ns/1ps

module cache_tag_array (
    input  logic                    clk,
    input  logic                    reset,
    input  cache_pkg::addr_t        lookup_addr,
    input  logic                    victim_way,
    input  logic                    tag_we,
    input  logic                    commit_hit_write,
    input  logic                    hit_way_set_dirty,
    output logic                    hit,
    output logic                    hit_way,
    output logic                    victim_dirty,
    output logic [cache_pkg::tag_w-1:0] victim_tag
);

    logic [cache_pkg::tag_w-1:0]    tag_mem [2][cache_pkg::num_sets];
    logic [cache_pkg::num_sets-1:0] valid_q [2];
    logic [cache_pkg::num_sets-1:0] dirty_q [2];
    logic [cache_pkg::index_w-1:0]  idx;
    logic [1:0]                     way_hit;

    assign idx = lookup_addr.f.index;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_mem[w][idx] == lookup_addr.f.tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // facts about the line that a miss would replace
    assign victim_dirty = valid_q[victim_way][idx] && dirty_q[victim_way][idx];
    assign victim_tag   = tag_mem[victim_way][idx];

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[victim_way][idx] <= lookup_addr.f.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
        end else begin
            if (tag_we) begin
                valid_q[victim_way][idx] <= 1'b1;
                // a store miss leaves its refilled line modified
                dirty_q[victim_way][idx] <= hit_way_set_dirty;
            end
            if (commit_hit_write) begin
                dirty_q[hit_way][idx] <= 1'b1;
            end
        end
    end

    // a tag lives in at most one way of a set
    a_single_way_hit: assert property (@(posedge clk) disable iff (reset)
        !(way_hit[0] && way_hit[1]));

endmodule

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  cache_pkg::cpu_req_t req,
    input  logic                hit,
    input  logic                victim_dirty,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  logic                wr_rdy,
    output cache_pkg::state_t   state,
    output cache_pkg::cpu_req_t req_q,
    output logic                addr_ok,
    output logic                data_ok,
    output logic                rd_req,
    output logic                wr_req,
    output logic                tag_we,
    output logic                commit_hit_write
);

    cache_pkg::state_t state_next;
    logic              latch_req;
    logic              last_beat;

    assign addr_ok   = (state == cache_pkg::idle);
    assign latch_req = valid && addr_ok;
    assign last_beat = ret_valid && ret_last;

    // request register for the one access in flight
    always_ff @(posedge clk) begin
        if (latch_req) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next       = state;
        data_ok          = 1'b0;
        rd_req           = 1'b0;
        wr_req           = 1'b0;
        tag_we           = 1'b0;
        commit_hit_write = 1'b0;
        case (state)
            cache_pkg::idle: begin
                if (latch_req) begin
                    state_next = cache_pkg::lookup;
                end
            end
            cache_pkg::lookup: begin
                if (hit) begin
                    data_ok          = 1'b1;
                    commit_hit_write = (req_q.op == cache_pkg::op_write);
                    state_next       = cache_pkg::idle;
                end else begin
                    state_next = cache_pkg::miss;
                end
            end
            cache_pkg::miss: begin
                // a dirty victim goes out first and a clean one is dropped
                wr_req = victim_dirty;
                if (!victim_dirty || wr_rdy) begin
                    state_next = cache_pkg::replace;
                end
            end
            cache_pkg::replace: begin
                rd_req = 1'b1;
                if (rd_rdy) begin
                    state_next = cache_pkg::refill;
                end
            end
            cache_pkg::refill: begin
                if (last_beat) begin
                    data_ok    = 1'b1;
                    tag_we     = 1'b1; // install tag with the last data beat
                    state_next = cache_pkg::idle;
                end
            end
            default: begin
                state_next = cache_pkg::idle;
            end
        endcase
    end

    // the two bus requests never overlap
    a_one_bus_req: assert property (@(posedge clk) disable iff (reset)
        !(rd_req && wr_req));

    // no reply without an access in flight
    a_no_reply_in_idle: assert property (@(posedge clk) disable iff (reset)
        data_ok |-> (state != cache_pkg::idle));

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

    // geometry, fixed by the address split below
    localparam int offset_w       = 4;
    localparam int index_w        = 8;
    localparam int tag_w          = 20;
    localparam int num_sets       = 256;
    localparam int words_per_line = 4;

    // cpu op codes
    localparam logic op_read  = 1'b0;
    localparam logic op_write = 1'b1;

    // block transfer type, same code on the read and write bus
    localparam logic [2:0] bus_block = 3'b100;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        replace,
        refill
    } state_t;

    typedef logic [127:0] line_t;

    // one address word, seen either as a bus address or as cache coordinates
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
            logic [1:0]         bank;     // word within the line
            logic [1:0]         byte_sel; // byte within the word
        } f;
    } addr_t;

    typedef struct packed {
        logic        op;
        addr_t       addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [2:0]  rd_type;
        logic [31:0] rd_addr;
    } rd_bus_t;

    typedef struct packed {
        logic [2:0]  wr_type;
        logic [31:0] wr_addr;
        line_t       wr_data;
    } wr_bus_t;

endpackage
